/* Makefile */
TOP = tb_audio_recorder

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -f build.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --assert -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+verilog
+incdir+tb
verilog/aud_pkg.sv
verilog/ctrl_pkg.sv
verilog/i2s_capture.sv
verilog/sample_store.sv
verilog/speed_dsp.sv
verilog/i2s_serializer.sv
verilog/recorder_ctrl.sv
verilog/audio_recorder_top.sv
tb/tb_audio_recorder.sv

/* tb/tb_i2s_tasks.svh */
`ifndef TB_I2S_TASKS_SVH
`define TB_I2S_TASKS_SVH

// codec model state, one frame is 64 bit clocks with the left half low
int          phase = 32;
integer      seed = 32'hc1c5d9ab;
logic        capture_on = 1'b0;
logic        collect_on = 1'b0;
logic        expect_silence = 1'b0;
logic [15:0] rec_q[$];
logic [15:0] dac_q[$];

// nonzero so a played word never looks like silence
function automatic logic [15:0] random_word();
	logic [15:0] w;
	w = 16'($random(seed));
	while (w == 16'd0) begin
		w = 16'($random(seed));
	end
	return w;
endfunction

function automatic int count_nonzero();
	int n;
	n = 0;
	foreach (dac_q[i]) begin
		if (dac_q[i] != 16'd0) begin
			n++;
		end
	end
	return n;
endfunction

// phase p drives lrck and the adc bit, dac bit of the same word is read back at phase p
task automatic run_codec();
	logic [15:0] adc_word;
	logic [15:0] dac_word;
	adc_word = '0;
	dac_word = '0;
	forever begin
		@(posedge aud_bclk);
		#1;
		if (phase >= 1 && phase <= 16) begin
			dac_word = {dac_word[14:0], dacdat};
		end else begin
			assert (dacdat == 1'b0)
			else fail_now($sformatf("DAC data was not zero outside the left word, phase %0d",
				phase));
		end
		if (phase == 0) begin
			adc_word = random_word();
			if (capture_on) begin
				rec_q.push_back(adc_word);
			end
		end
		if (phase == 17) begin
			if (collect_on) begin
				dac_q.push_back(dac_word);
			end
			if (expect_silence) begin
				assert (dac_word == 16'd0)
				else fail_now($sformatf("FAIL silence expected 0 actual %0h", dac_word));
			end
		end
		lrck   = (phase >= 32);
		adcdat = (phase >= 1 && phase <= 16) ? adc_word[16 - phase] : 1'b0;
		phase  = (phase + 1) % FRAME;
	end
endtask

// sampled on the edge, the codec moves phase 1 ns later
task automatic wait_frame_phase(input int p);
	int n;
	n = 0;
	@(posedge aud_bclk);
	while (phase != p && n < 2 * FRAME) begin
		@(posedge aud_bclk);
		n++;
	end
	assert (phase == p) else fail_now("timed out waiting for the codec frame phase");
endtask

task automatic wait_recorded(input int words);
	int n;
	n = 0;
	while (rec_q.size() < words && n < (words + 4) * FRAME) begin
		@(posedge aud_bclk);
		n++;
	end
	assert (rec_q.size() >= words) else fail_now("timed out waiting for ADC words to record");
endtask

task automatic wait_played(input int words);
	int n;
	n = 0;
	while (count_nonzero() < words && n < (words + 4) * FRAME) begin
		@(posedge aud_bclk);
		n++;
	end
	assert (count_nonzero() >= words) else fail_now("timed out waiting for played DAC words");
endtask

`endif

/* tb/tb_audio_recorder.sv */
`timescale 1ns/1ps
`include "aud_params.svh"

module tb_audio_recorder;

localparam int FRAME    = 64;
localparam int KEY_REC  = 0;
localparam int KEY_PLAY = 1;
localparam int KEY_STOP = 2;

logic                  aud_bclk;
logic                  rst_n;
logic                  key_rec;
logic                  key_play;
logic                  key_stop;
ctrl_pkg::play_mode_e  mode;
aud_pkg::speed_t       speed;
logic                  lrck;
logic                  adcdat;
logic                  dacdat;
ctrl_pkg::ctrl_state_e status;
aud_pkg::len_t         rec_len;
logic [15:0]           exp_q[$];

`include "tb_i2s_tasks.svh"

audio_recorder_top uut (
	.i_AUD_BCLK    (aud_bclk),
	.i_rst_n       (rst_n),
	.i_key_rec     (key_rec),
	.i_key_play    (key_play),
	.i_key_stop    (key_stop),
	.i_mode        (mode),
	.i_speed       (speed),
	.i_AUD_ADCLRCK (lrck),
	.i_AUD_ADCDAT  (adcdat),
	.i_AUD_DACLRCK (lrck),
	.o_AUD_DACDAT  (dacdat),
	.o_status      (status),
	.o_rec_len     (rec_len)
);

initial begin
	aud_bclk = 1'b0;
end

always #5 aud_bclk = ~aud_bclk;

initial begin
	run_codec();
end

task automatic fail_now(input string what);
	$display("%s", what);
	$display("Simulation failed");
	$fatal(1);
endtask

task automatic check_value(input string test, input longint expected, input longint actual);
	assert (expected == actual)
	else fail_now($sformatf("FAIL %s expected %0h actual %0h", test, expected, actual));
endtask

task automatic wait_status(input string test, input ctrl_pkg::ctrl_state_e want, input int limit);
	int n;
	n = 0;
	while (status != want && n < limit) begin
		@(posedge aud_bclk);
		n++;
	end
	assert (status == want)
	else fail_now($sformatf("FAIL %s expected state %0d actual state %0d", test, want, status));
endtask

task automatic set_key(input int which, input logic level);
	case (which)
		KEY_REC:  key_rec = level;
		KEY_PLAY: key_play = level;
		default:  key_stop = level;
	endcase
endtask

// presses land mid frame away from the capture write at phase 17
task automatic press_key(input int which);
	wait_frame_phase(40);
	#1;
	set_key(which, 1'b0);
	repeat (4) @(posedge aud_bclk);
	#1;
	set_key(which, 1'b1);
endtask

// reference model of the four playback modes built from the recorded words
function automatic void build_expected(input ctrl_pkg::play_mode_e m, input int n);
	int     i;
	int     k;
	longint cur;
	longint nxt;
	longint recip;
	longint p;
	exp_q.delete();
	recip = (65536 + n - 1) / n;
	i = 0;
	while (i < rec_q.size()) begin
		cur = longint'($signed(rec_q[i]));
		nxt = (i + 1 < rec_q.size()) ? longint'($signed(rec_q[i + 1])) : cur;
		case (m)
			ctrl_pkg::PM_SLOW_CONST: begin
				for (k = 0; k < n; k++) begin
					exp_q.push_back(rec_q[i]);
				end
			end
			ctrl_pkg::PM_SLOW_LIN: begin
				for (k = 0; k < n; k++) begin
					p = (nxt - cur) * k * recip;
					exp_q.push_back(16'(cur + (p >>> 16)));
				end
			end
			default: exp_q.push_back(rec_q[i]);
		endcase
		i = i + ((m == ctrl_pkg::PM_FAST) ? n : 1);
	end
endfunction

// leading zero words come before the first sample reaches the DAC
task automatic compare_played(input string test);
	int first;
	int j;
	first = 0;
	while (first < dac_q.size() && dac_q[first] == 16'd0) begin
		first++;
	end
	assert (dac_q.size() - first >= exp_q.size())
	else fail_now($sformatf("%s played only %0d of %0d words", test,
		dac_q.size() - first, exp_q.size()));
	for (j = 0; j < exp_q.size(); j++) begin
		check_value($sformatf("%s word %0d", test, j), exp_q[j], dac_q[first + j]);
	end
	for (j = first + exp_q.size(); j < dac_q.size(); j++) begin
		check_value($sformatf("%s trailing word %0d", test, j), 0, dac_q[j]);
	end
endtask

task automatic play_and_check(input string test, input ctrl_pkg::play_mode_e m, input int n);
	build_expected(m, n);
	wait_frame_phase(30);
	#1;
	mode  = m;
	speed = aud_pkg::speed_t'(n - 1);
	dac_q.delete();
	collect_on = 1'b1;
	press_key(KEY_PLAY);
	wait_status({test, " start"}, ctrl_pkg::ST_PLAY, 8);
	wait_status({test, " end"}, ctrl_pkg::ST_STOP, (exp_q.size() + 4) * FRAME);
	// last word is still in flight after done
	repeat (3 * FRAME) @(posedge aud_bclk);
	#1;
	collect_on = 1'b0;
	compare_played(test);
endtask

task automatic pause_and_stop_play();
	int j;
	wait_frame_phase(30);
	#1;
	mode  = ctrl_pkg::PM_NORMAL;
	speed = '0;
	dac_q.delete();
	collect_on = 1'b1;
	press_key(KEY_PLAY);
	wait_status("pause play", ctrl_pkg::ST_PLAY, 8);
	wait_played(10);
	press_key(KEY_PLAY);
	wait_status("pause enter", ctrl_pkg::ST_PLAY_PAUSE, 8);
	// one held sample may still drain
	repeat (2 * FRAME) @(posedge aud_bclk);
	#1;
	expect_silence = 1'b1;
	repeat (4 * FRAME) @(posedge aud_bclk);
	#1;
	expect_silence = 1'b0;
	press_key(KEY_PLAY);
	wait_status("pause resume", ctrl_pkg::ST_PLAY, 8);
	wait_played(20);
	press_key(KEY_PLAY);
	wait_status("pause again", ctrl_pkg::ST_PLAY_PAUSE, 8);
	repeat (2 * FRAME) @(posedge aud_bclk);
	press_key(KEY_STOP);
	wait_status("stop from pause", ctrl_pkg::ST_STOP, 8);
	repeat (2 * FRAME) @(posedge aud_bclk);
	#1;
	collect_on = 1'b0;
	// no repeats or gaps across the pause
	j = 0;
	foreach (dac_q[i]) begin
		if (dac_q[i] != 16'd0) begin
			check_value($sformatf("pause word %0d", j), rec_q[j], dac_q[i]);
			j++;
		end
	end
	assert (j >= 20 && j < 30)
	else fail_now($sformatf("pause test played %0d words before the stop", j));
endtask

initial begin
	key_rec  = 1'b1;
	key_play = 1'b1;
	key_stop = 1'b1;
	mode     = ctrl_pkg::PM_NORMAL;
	speed    = '0;
	lrck     = 1'b1;
	adcdat   = 1'b0;
	rst_n    = 1'b1;
	repeat (16) @(posedge aud_bclk);
	#1;
	rst_n = 1'b0;

	// reset state and an idle DAC
	check_value("reset status", ctrl_pkg::ST_STOP, status);
	check_value("reset length", 0, rec_len);
	expect_silence = 1'b1;
	repeat (3 * FRAME) @(posedge aud_bclk);
	#1;
	expect_silence = 1'b0;

	// record 20 words then pause and record 10 more
	press_key(KEY_REC);
	capture_on = 1'b1;
	wait_status("record start", ctrl_pkg::ST_RECD, 8);
	wait_recorded(20);
	press_key(KEY_REC);
	capture_on = 1'b0;
	wait_status("record pause", ctrl_pkg::ST_RECD_PAUSE, 8);
	repeat (3 * FRAME) @(posedge aud_bclk);
	check_value("paused length", 20, rec_len);
	press_key(KEY_REC);
	capture_on = 1'b1;
	wait_status("record resume", ctrl_pkg::ST_RECD, 8);
	wait_recorded(30);
	press_key(KEY_REC);
	capture_on = 1'b0;
	wait_status("record pause again", ctrl_pkg::ST_RECD_PAUSE, 8);
	press_key(KEY_STOP);
	wait_status("record stop", ctrl_pkg::ST_STOP, 8);
	check_value("record length", 30, rec_len);

	play_and_check("normal play", ctrl_pkg::PM_NORMAL, 1);
	play_and_check("fast play", ctrl_pkg::PM_FAST, 3);
	play_and_check("slow constant play", ctrl_pkg::PM_SLOW_CONST, 4);
	play_and_check("slow linear play", ctrl_pkg::PM_SLOW_LIN, 4);
	pause_and_stop_play();

	// store fills and ends recording by itself
	press_key(KEY_REC);
	wait_status("full start", ctrl_pkg::ST_RECD, 8);
	wait_status("full stop", ctrl_pkg::ST_STOP, (`AUD_DEPTH + 40) * FRAME);
	check_value("full length", `AUD_DEPTH, rec_len);

	$display("Simulation passed");
	$finish;
end

endmodule

/* verilog/aud_params.svh */
`ifndef AUD_PARAMS_SVH
`define AUD_PARAMS_SVH

// codec word width
`define AUD_SAMPLE_W 16

// on-chip sample store
`define AUD_ADDR_W 10
`define AUD_DEPTH 1024

// speed field, factor N is field + 1
`define AUD_SPEED_W 3
`define AUD_SPEED_MAX 8

`endif

/* verilog/aud_pkg.sv */
`include "aud_params.svh"

package aud_pkg;

// one codec sample, two's complement
typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

// sample store address
typedef logic [`AUD_ADDR_W-1:0] addr_t;

// one extra bit so a completely full store is representable
typedef logic [`AUD_ADDR_W:0] len_t;

// playback speed field
typedef logic [`AUD_SPEED_W-1:0] speed_t;

// captured left word from the ADC
typedef struct packed {
	logic    valid;
	sample_t data;
} sample_beat_t;

endpackage

/* verilog/audio_recorder_top.sv */
`timescale 1ns/1ps

module audio_recorder_top (
	input  logic                  i_AUD_BCLK,
	input  logic                  i_rst_n,
	input  logic                  i_key_rec,
	input  logic                  i_key_play,
	input  logic                  i_key_stop,
	input  ctrl_pkg::play_mode_e  i_mode,
	input  aud_pkg::speed_t       i_speed,
	input  logic                  i_AUD_ADCLRCK,
	input  logic                  i_AUD_ADCDAT,
	input  logic                  i_AUD_DACLRCK,
	output logic                  o_AUD_DACDAT,
	output ctrl_pkg::ctrl_state_e o_status,
	output aud_pkg::len_t         o_rec_len
);

// control to datapath
logic                rec_en, rec_clear, full, play_done;
ctrl_pkg::play_cmd_t cmd;

// capture to store
aud_pkg::sample_beat_t beat;

// store read port
logic             rd_valid, rd_ready, rd_data_valid;
aud_pkg::addr_t   rd_addr;
aud_pkg::sample_t rd_data;

// dsp to serializer
logic             out_valid, out_ready;
aud_pkg::sample_t out_sample;

recorder_ctrl u_ctrl (
	.i_AUD_BCLK  (i_AUD_BCLK),
	.i_rst_n     (i_rst_n),
	.i_key_rec   (i_key_rec),
	.i_key_play  (i_key_play),
	.i_key_stop  (i_key_stop),
	.i_mode      (i_mode),
	.i_speed     (i_speed),
	.i_full      (full),
	.i_play_done (play_done),
	.o_rec_en    (rec_en),
	.o_rec_clear (rec_clear),
	.o_cmd       (cmd),
	.o_status    (o_status)
);

i2s_capture u_capture (
	.i_AUD_BCLK (i_AUD_BCLK),
	.i_rst_n    (i_rst_n),
	.i_lrck     (i_AUD_ADCLRCK),
	.i_adcdat   (i_AUD_ADCDAT),
	.o_beat     (beat)
);

sample_store u_store (
	.i_AUD_BCLK      (i_AUD_BCLK),
	.i_rst_n         (i_rst_n),
	.i_wr_beat       (beat),
	.i_rec_en        (rec_en),
	.i_rec_clear     (rec_clear),
	.i_rd_valid      (rd_valid),
	.i_rd_addr       (rd_addr),
	.o_rd_ready      (rd_ready),
	.o_rd_data       (rd_data),
	.o_rd_data_valid (rd_data_valid),
	.o_len           (o_rec_len),
	.o_full          (full)
);

speed_dsp u_dsp (
	.i_AUD_BCLK      (i_AUD_BCLK),
	.i_rst_n         (i_rst_n),
	.i_cmd           (cmd),
	.i_len           (o_rec_len),
	.i_rd_ready      (rd_ready),
	.i_rd_data       (rd_data),
	.i_rd_data_valid (rd_data_valid),
	.i_out_ready     (out_ready),
	.o_rd_valid      (rd_valid),
	.o_rd_addr       (rd_addr),
	.o_out_valid     (out_valid),
	.o_out_sample    (out_sample),
	.o_done          (play_done)
);

i2s_serializer u_serializer (
	.i_AUD_BCLK (i_AUD_BCLK),
	.i_rst_n    (i_rst_n),
	.i_lrck     (i_AUD_DACLRCK),
	.i_valid    (out_valid),
	.i_sample   (out_sample),
	.o_ready    (out_ready),
	.o_dacdat   (o_AUD_DACDAT)
);

endmodule

/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

// recorder FSM states, also shown on the status output
typedef enum logic [2:0] {
	ST_STOP       = 3'd0,
	ST_RECD       = 3'd1,
	ST_RECD_PAUSE = 3'd2,
	ST_PLAY       = 3'd3,
	ST_PLAY_PAUSE = 3'd4
} ctrl_state_e;

// playback modes
typedef enum logic [1:0] {
	PM_NORMAL     = 2'd0,
	PM_FAST       = 2'd1,
	PM_SLOW_CONST = 2'd2,
	PM_SLOW_LIN   = 2'd3
} play_mode_e;

// controller to dsp
// start is a single-cycle pulse, run a level for the whole play phase
typedef struct packed {
	logic            start;
	logic            run;
	play_mode_e      mode;
	aud_pkg::speed_t speed;
} play_cmd_t;

endpackage

/* verilog/i2s_capture.sv */
`timescale 1ns/1ps
`include "aud_params.svh"

module i2s_capture (
	input  logic                  i_AUD_BCLK,
	input  logic                  i_rst_n,
	input  logic                  i_lrck,
	input  logic                  i_adcdat,
	output aud_pkg::sample_beat_t o_beat
);

localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);

logic             lrck_r;
logic             lrck_fall;
logic [CNT_W-1:0] bit_cnt_r;
logic             beat_valid_r;
aud_pkg::sample_t shift_r;

// low half of lrck is the left channel
assign lrck_fall = lrck_r & ~i_lrck;

// shift register already holds the full word once the count runs out
assign o_beat.valid = beat_valid_r;
assign o_beat.data  = shift_r;

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		lrck_r       <= 1'b0;
		bit_cnt_r    <= '0;
		beat_valid_r <= 1'b0;
	end else begin
		lrck_r       <= i_lrck;
		beat_valid_r <= 1'b0;
		if (lrck_fall) begin
			// edge that sees the fall carries no data bit
			bit_cnt_r <= CNT_W'(`AUD_SAMPLE_W);
		end else if (bit_cnt_r != '0) begin
			bit_cnt_r    <= bit_cnt_r - 1'b1;
			beat_valid_r <= (bit_cnt_r == CNT_W'(1));
		end
	end
end

// msb first
always_ff @(posedge i_AUD_BCLK) begin
	if (!lrck_fall && bit_cnt_r != '0) begin
		shift_r <= {shift_r[`AUD_SAMPLE_W-2:0], i_adcdat};
	end
end

endmodule

/* verilog/i2s_serializer.sv */
`timescale 1ns/1ps
`include "aud_params.svh"

module i2s_serializer (
	input  logic             i_AUD_BCLK,
	input  logic             i_rst_n,
	input  logic             i_lrck,
	input  logic             i_valid,
	input  aud_pkg::sample_t i_sample,
	output logic             o_ready,
	output logic             o_dacdat
);

localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);

logic             lrck_r;
logic             lrck_fall;
logic             accept;
logic             hold_valid_r;
aud_pkg::sample_t hold_r;
aud_pkg::sample_t shift_r;
logic [CNT_W-1:0] bit_cnt_r;

assign lrck_fall = lrck_r & ~i_lrck;
assign o_ready   = ~hold_valid_r;
assign accept    = i_valid & o_ready;

// silent outside the 16 left-word bits, right word is always zero
assign o_dacdat = (bit_cnt_r != '0) & shift_r[`AUD_SAMPLE_W-1];

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		lrck_r       <= 1'b0;
		hold_valid_r <= 1'b0;
		bit_cnt_r    <= '0;
	end else begin
		lrck_r <= i_lrck;
		if (accept) begin
			hold_valid_r <= 1'b1;
		end else if (lrck_fall) begin
			hold_valid_r <= 1'b0;
		end
		if (lrck_fall) begin
			bit_cnt_r <= CNT_W'(`AUD_SAMPLE_W);
		end else if (bit_cnt_r != '0) begin
			bit_cnt_r <= bit_cnt_r - 1'b1;
		end
	end
end

always_ff @(posedge i_AUD_BCLK) begin
	if (accept) begin
		hold_r <= i_sample;
	end
	// an empty holding register plays a zero word
	if (lrck_fall) begin
		shift_r <= hold_valid_r ? hold_r : '0;
	end else begin
		shift_r <= shift_r << 1;
	end
end

endmodule

/* verilog/recorder_ctrl.sv */
`timescale 1ns/1ps

module recorder_ctrl (
	input  logic                  i_AUD_BCLK,
	input  logic                  i_rst_n,
	input  logic                  i_key_rec,
	input  logic                  i_key_play,
	input  logic                  i_key_stop,
	input  ctrl_pkg::play_mode_e  i_mode,
	input  aud_pkg::speed_t       i_speed,
	input  logic                  i_full,
	input  logic                  i_play_done,
	output logic                  o_rec_en,
	output logic                  o_rec_clear,
	output ctrl_pkg::play_cmd_t   o_cmd,
	output ctrl_pkg::ctrl_state_e o_status
);

ctrl_pkg::ctrl_state_e state_r, state_w;
ctrl_pkg::play_mode_e  mode_r, mode_w;
aud_pkg::speed_t       speed_r, speed_w;
logic                  key_rec_r, key_play_r, key_stop_r;
logic                  rec_fall, play_fall, stop_fall;
logic                  start_w;

// keys idle high, a press pulls them low
assign rec_fall  = key_rec_r & ~i_key_rec;
assign play_fall = key_play_r & ~i_key_play;
assign stop_fall = key_stop_r & ~i_key_stop;

assign o_status    = state_r;
assign o_rec_en    = (state_r == ctrl_pkg::ST_RECD);
assign o_cmd.start = start_w;
assign o_cmd.run   = (state_r == ctrl_pkg::ST_PLAY);
assign o_cmd.mode  = mode_r;
assign o_cmd.speed = speed_r;

always_comb begin
	state_w     = state_r;
	mode_w      = mode_r;
	speed_w     = speed_r;
	start_w     = 1'b0;
	o_rec_clear = 1'b0;
	case (state_r)
		ctrl_pkg::ST_STOP: begin
			if (rec_fall) begin
				state_w     = ctrl_pkg::ST_RECD;
				o_rec_clear = 1'b1;
			end else if (play_fall) begin
				// mode and speed are frozen for the whole playback
				state_w = ctrl_pkg::ST_PLAY;
				start_w = 1'b1;
				mode_w  = i_mode;
				speed_w = i_speed;
			end
		end
		ctrl_pkg::ST_RECD: begin
			if (i_full) begin
				state_w = ctrl_pkg::ST_STOP;
			end else if (rec_fall) begin
				state_w = ctrl_pkg::ST_RECD_PAUSE;
			end
		end
		ctrl_pkg::ST_RECD_PAUSE: begin
			if (rec_fall) begin
				state_w = ctrl_pkg::ST_RECD;
			end else if (stop_fall) begin
				state_w = ctrl_pkg::ST_STOP;
			end
		end
		ctrl_pkg::ST_PLAY: begin
			if (i_play_done) begin
				state_w = ctrl_pkg::ST_STOP;
			end else if (play_fall) begin
				state_w = ctrl_pkg::ST_PLAY_PAUSE;
			end
		end
		ctrl_pkg::ST_PLAY_PAUSE: begin
			if (play_fall) begin
				state_w = ctrl_pkg::ST_PLAY;
			end else if (stop_fall) begin
				state_w = ctrl_pkg::ST_STOP;
			end
		end
		default: state_w = ctrl_pkg::ST_STOP;
	endcase
end

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		state_r    <= ctrl_pkg::ST_STOP;
		mode_r     <= ctrl_pkg::PM_NORMAL;
		speed_r    <= '0;
		key_rec_r  <= 1'b1;
		key_play_r <= 1'b1;
		key_stop_r <= 1'b1;
	end else begin
		state_r    <= state_w;
		mode_r     <= mode_w;
		speed_r    <= speed_w;
		key_rec_r  <= i_key_rec;
		key_play_r <= i_key_play;
		key_stop_r <= i_key_stop;
	end
end

endmodule

/* verilog/sample_store.sv */
`timescale 1ns/1ps
`include "aud_params.svh"

module sample_store (
	input  logic                  i_AUD_BCLK,
	input  logic                  i_rst_n,
	input  aud_pkg::sample_beat_t i_wr_beat,
	input  logic                  i_rec_en,
	input  logic                  i_rec_clear,
	input  logic                  i_rd_valid,
	input  aud_pkg::addr_t        i_rd_addr,
	output logic                  o_rd_ready,
	output aud_pkg::sample_t      o_rd_data,
	output logic                  o_rd_data_valid,
	output aud_pkg::len_t         o_len,
	output logic                  o_full
);

aud_pkg::sample_t mem [`AUD_DEPTH];
aud_pkg::addr_t   wr_addr_r;
aud_pkg::len_t    len_r;
logic             wr_en;

assign o_full = (len_r == aud_pkg::len_t'(`AUD_DEPTH));
assign o_len  = len_r;

// writes stop at full, a clear wins over a write
assign wr_en = i_rec_en & i_wr_beat.valid & ~o_full & ~i_rec_clear;

// the read side never stalls
assign o_rd_ready = 1'b1;

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		wr_addr_r       <= '0;
		len_r           <= '0;
		o_rd_data_valid <= 1'b0;
	end else begin
		o_rd_data_valid <= i_rd_valid & o_rd_ready;
		if (i_rec_clear) begin
			wr_addr_r <= '0;
			len_r     <= '0;
		end else if (wr_en) begin
			wr_addr_r <= wr_addr_r + 1'b1;
			len_r     <= len_r + 1'b1;
		end
	end
end

always_ff @(posedge i_AUD_BCLK) begin
	if (wr_en) begin
		mem[wr_addr_r] <= i_wr_beat.data;
	end
	if (i_rd_valid) begin
		o_rd_data <= mem[i_rd_addr];
	end
end

endmodule

/* verilog/speed_dsp.sv */
`timescale 1ns/1ps
`include "aud_params.svh"

module speed_dsp (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  ctrl_pkg::play_cmd_t i_cmd,
	input  aud_pkg::len_t       i_len,
	input  logic                i_rd_ready,
	input  aud_pkg::sample_t    i_rd_data,
	input  logic                i_rd_data_valid,
	input  logic                i_out_ready,
	output logic                o_rd_valid,
	output aud_pkg::addr_t      o_rd_addr,
	output logic                o_out_valid,
	output aud_pkg::sample_t    o_out_sample,
	output logic                o_done
);

typedef enum logic [2:0] {
	D_IDLE,
	D_FETCH_A,
	D_WAIT_A,
	D_FETCH_B,
	D_WAIT_B,
	D_EMIT,
	D_FIN
} dsp_state_e;

// 65536 / N rounded up, N = 1 .. 8
localparam logic [16:0] RECIP [`AUD_SPEED_MAX] = '{
	17'd65536, 17'd32768, 17'd21846, 17'd16384,
	17'd13108, 17'd10923, 17'd9363, 17'd8192
};

dsp_state_e         state_r, state_w;
aud_pkg::len_t      idx_r, idx_w;
aud_pkg::speed_t    k_r, k_w;
aud_pkg::sample_t   cur_r, nxt_r;
aud_pkg::len_t      step_w, idx_next;
logic               lin, slow, last_rep, has_next;
logic signed [16:0] diff_w;
logic signed [39:0] prod_w;
aud_pkg::sample_t   lin_sample;

assign lin      = (i_cmd.mode == ctrl_pkg::PM_SLOW_LIN);
assign slow     = lin | (i_cmd.mode == ctrl_pkg::PM_SLOW_CONST);
assign last_rep = (k_r == i_cmd.speed);
assign has_next = (idx_r + aud_pkg::len_t'(1)) < i_len;

// fast mode skips N samples, every other mode steps by one
assign step_w   = (i_cmd.mode == ctrl_pkg::PM_FAST) ?
		aud_pkg::len_t'(i_cmd.speed) + aud_pkg::len_t'(1) : aud_pkg::len_t'(1);
assign idx_next = idx_r + step_w;

// s[i] + (s[i+1] - s[i]) * k / N
assign diff_w     = nxt_r - cur_r;
assign prod_w     = diff_w * $signed({1'b0, k_r}) * $signed({1'b0, RECIP[i_cmd.speed]});
assign lin_sample = cur_r + aud_pkg::sample_t'(prod_w >>> 16);

assign o_out_valid  = (state_r == D_EMIT) & i_cmd.run;
assign o_out_sample = lin ? lin_sample : cur_r;
assign o_done       = (state_r == D_FIN) & i_cmd.run;

always_comb begin
	state_w    = state_r;
	idx_w      = idx_r;
	k_w        = k_r;
	o_rd_valid = 1'b0;
	o_rd_addr  = aud_pkg::addr_t'(idx_r);
	case (state_r)
		D_FETCH_A: begin
			o_rd_valid = i_cmd.run;
			if (i_cmd.run && i_rd_ready) begin
				state_w = D_WAIT_A;
			end
		end
		D_WAIT_A: begin
			if (i_rd_data_valid) begin
				state_w = (lin && has_next) ? D_FETCH_B : D_EMIT;
			end
		end
		D_FETCH_B: begin
			o_rd_valid = i_cmd.run;
			o_rd_addr  = aud_pkg::addr_t'(idx_r + aud_pkg::len_t'(1));
			if (i_cmd.run && i_rd_ready) begin
				state_w = D_WAIT_B;
			end
		end
		D_WAIT_B: begin
			if (i_rd_data_valid) begin
				state_w = D_EMIT;
			end
		end
		D_EMIT: begin
			if (o_out_valid && i_out_ready) begin
				if (slow && !last_rep) begin
					k_w = k_r + 1'b1;
				end else begin
					k_w     = '0;
					idx_w   = idx_next;
					state_w = (idx_next < i_len) ? D_FETCH_A : D_FIN;
				end
			end
		end
		D_FIN: begin
			if (i_cmd.run) begin
				state_w = D_IDLE;
			end
		end
		default: ;
	endcase
	// restart from the first sample
	if (i_cmd.start) begin
		idx_w   = '0;
		k_w     = '0;
		state_w = (i_len == '0) ? D_FIN : D_FETCH_A;
	end
end

always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
	if (i_rst_n) begin
		state_r <= D_IDLE;
		idx_r   <= '0;
		k_r     <= '0;
	end else begin
		state_r <= state_w;
		idx_r   <= idx_w;
		k_r     <= k_w;
	end
end

always_ff @(posedge i_AUD_BCLK) begin
	if (state_r == D_WAIT_A && i_rd_data_valid) begin
		cur_r <= i_rd_data;
		// last index interpolates against itself
		nxt_r <= i_rd_data;
	end
	if (state_r == D_WAIT_B && i_rd_data_valid) begin
		nxt_r <= i_rd_data;
	end
end

endmodule
